// File: memFlash.f
+incdir+.
memFlashPkg.sv
flashRom.sv
resetController.sv
flashSequencer.sv
memoryBank.sv
memFlashTop.sv
memFlashTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the memFlash testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f memFlash.f --top-module memFlashTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/VmemFlashTb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Testbench passed$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: memFlashTb.sv
`include "memFlash_defs.svh"

module memFlashTb import memFlashPkg::*; ;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] pulseNone = 2'd0;
    localparam logic [1:0] pulseTrig = 2'd1;
    localparam logic [1:0] pulseResp = 2'd2;
    localparam logic [1:0] memNone   = 2'd0;
    localparam logic [1:0] memInst   = 2'd1;
    localparam logic [1:0] memData   = 2'd2;

    localparam int numRows        = 8;
    localparam int watchdogCycles = numRows * 4000 + 4000;
    localparam int flashWaitLimit = 3000; // One copy phase plus drain fits easily
    localparam int quietCycles    = 12;   // Window after a pulse that must stay silent
    localparam int spotCount      = 40;

    typedef struct packed {
        logic       resetFirst; // Pulse rstN before the vector
        logic [3:0] vector;
        logic [1:0] pulse;
        logic       lock;
        logic [1:0] recheck;
    } scenarioT;

    // Vector bits from the left are full, instruction, IO and data
    scenarioT scenarios [numRows] = '{
        '{1'b0, 4'b0001, pulseResp, 1'b0, memData},  // Data reset
        '{1'b0, 4'b1000, pulseTrig, 1'b0, memNone},  // Full reset
        '{1'b0, 4'b0100, pulseTrig, 1'b0, memInst},  // Instruction reset
        '{1'b0, 4'b1001, pulseTrig, 1'b0, memNone},  // Full wins over data
        '{1'b0, 4'b0010, pulseTrig, 1'b1, memNone},  // IO reset sets the lockout
        '{1'b0, 4'b0001, pulseNone, 1'b1, memNone},  // Locked out
        '{1'b0, 4'b1000, pulseNone, 1'b1, memNone},
        '{1'b1, 4'b1000, pulseTrig, 1'b0, memNone}   // Hardware reset clears the lock
    };

    logic       clk;
    logic       rstN;
    logic       flashInit;
    logic       softwareReset;
    logic [3:0] resetVector;
    logic       resetTrigger;
    logic       resetResponse;
    logic       cpuResetLockout;
    logic       systemEnable;
    logic       rdSel;
    memAddrT    rdAddr;
    wordT       rdData;
    int         seed = 43;

    memFlashTop UUT (
        .clk            (clk),
        .rstN           (rstN),
        .flashInit      (flashInit),
        .softwareReset  (softwareReset),
        .resetVector    (resetVector),
        .resetTrigger   (resetTrigger),
        .resetResponse  (resetResponse),
        .cpuResetLockout(cpuResetLockout),
        .systemEnable   (systemEnable),
        .rdSel          (rdSel),
        .rdAddr         (rdAddr),
        .rdData         (rdData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic failTimeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    // Address XOR key and then a left rotate by the low three address bits
    function automatic wordT romWord(input memAddrT a, input wordT key);
        wordT w;
        w = {6'b000000, a} ^ key;
        for (int n = 0; n < int'(a[2:0]); n++) begin
            w = {w[14:0], w[15]};
        end
        return w;
    endfunction

    function automatic wordT expectedWord(input logic [1:0] mem, input memAddrT a);
        if (mem == memInst) begin
            return romWord(a, `INST_ROM_KEY);
        end
        if ((a >= `MEMMAP_START) && (a <= `MEMMAP_END)) begin
            return '0; // I/O window is never flashed
        end
        return romWord(a, `DATA_ROM_KEY);
    endfunction

    task automatic readWord(input logic [1:0] mem, input memAddrT a, output wordT value);
        rdSel  = (mem == memData);
        rdAddr = a;
        nextCycle();
        value = rdData;
    endtask

    task automatic checkAddr(input logic [1:0] mem, input memAddrT a, input string tag);
        wordT value;
        readWord(mem, a, value);
        checkWord($sformatf("%s %s[%0d]", tag, (mem == memInst) ? "inst" : "data", a),
                  expectedWord(mem, a), value);
    endtask

    task automatic checkWholeMemory(input logic [1:0] mem, input string tag);
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            checkAddr(mem, memAddrT'(a), tag);
        end
    endtask

    // Window edges first and then random addresses
    task automatic spotCheck(input logic [1:0] mem, input string tag);
        checkAddr(mem, memAddrT'(0), tag);
        checkAddr(mem, memAddrT'(`MEM_DEPTH - 1), tag);
        checkAddr(mem, memAddrT'(`MEMMAP_START - 1), tag);
        checkAddr(mem, memAddrT'(`MEMMAP_START), tag);
        checkAddr(mem, memAddrT'(`MEMMAP_END), tag);
        checkAddr(mem, memAddrT'(`MEMMAP_END + 1), tag);
        for (int k = 0; k < spotCount; k++) begin
            checkAddr(mem, memAddrT'($random(seed)), tag);
        end
    endtask

    task automatic applyHardReset(input string tag);
        rstN = 1'b0;
        repeat (10) nextCycle();
        rstN = 1'b1;
        checkBit({tag, " resetTrigger"}, 1'b0, resetTrigger);
        checkBit({tag, " resetResponse"}, 1'b0, resetResponse);
        checkBit({tag, " cpuResetLockout"}, 1'b0, cpuResetLockout);
        checkBit({tag, " systemEnable"}, 1'b0, systemEnable);
        checkBit({tag, " instWrEn"}, 1'b0, UUT.instWrEn);
        checkBit({tag, " dataWrEn"}, 1'b0, UUT.dataWrEn);
    endtask

    task automatic runScenario(input int i);
        scenarioT r;
        string    tag;
        int       waited;
        int       silence;
        r   = scenarios[i];
        tag = $sformatf("row %0d", i);
        if (r.resetFirst) begin
            applyHardReset({tag, " hw reset"});
        end
        if (r.recheck != memNone) begin
            spotCheck(r.recheck, {tag, " before"});
        end
        softwareReset = 1'b1;
        resetVector   = r.vector;
        nextCycle();
        softwareReset = 1'b0;
        resetVector   = 4'b0000;
        // Flashing resets answer only after the copy and the rest answer at once
        if ((r.recheck != memNone) && (r.pulse != pulseNone)) begin
            waited = 0;
            while (!(resetTrigger || resetResponse)) begin
                if (waited >= flashWaitLimit) begin
                    failTimeout($sformatf("the reset pulse of row %0d", i));
                end
                nextCycle();
                waited++;
            end
        end
        checkBit({tag, " resetTrigger"}, r.pulse == pulseTrig, resetTrigger);
        checkBit({tag, " resetResponse"}, r.pulse == pulseResp, resetResponse);
        // A wrongly taken data reset would only answer after a whole copy
        silence = (r.pulse == pulseNone) ? flashWaitLimit : quietCycles;
        repeat (silence) begin
            nextCycle();
            checkBit({tag, " resetTrigger after pulse"}, 1'b0, resetTrigger);
            checkBit({tag, " resetResponse after pulse"}, 1'b0, resetResponse);
        end
        checkBit({tag, " cpuResetLockout"}, r.lock, cpuResetLockout);
        if (r.recheck != memNone) begin
            spotCheck(r.recheck, {tag, " after"});
        end
    endtask

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run appears to hang", watchdogCycles);
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin
        int waited;
        rstN          = 1'b0;
        flashInit     = 1'b0;
        softwareReset = 1'b0;
        resetVector   = 4'b0000;
        rdSel         = 1'b0;
        rdAddr        = '0;
        applyHardReset("power-up");

        // Boot copy of both images
        flashInit = 1'b1;
        nextCycle();
        flashInit = 1'b0;
        waited = 0;
        while (!systemEnable) begin
            if (waited >= 2 * flashWaitLimit) begin
                failTimeout("systemEnable after flashInit");
            end
            nextCycle();
            waited++;
        end
        checkWholeMemory(memInst, "boot");
        checkWholeMemory(memData, "boot");

        for (int i = 0; i < numRows; i++) begin
            runScenario(i);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: memFlashTop.sv
module memFlashTop import memFlashPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       flashInit,
    input  logic       softwareReset,
    input  logic [3:0] resetVector,
    output logic       resetTrigger,
    output logic       resetResponse,
    output logic       cpuResetLockout,
    output logic       systemEnable,
    input  logic       rdSel,       // 0 instruction, 1 data
    input  memAddrT    rdAddr,
    output wordT       rdData
);

    logic    instFlashReq;
    logic    dataFlashReq;
    logic    lockLocal;
    logic    flashDone;
    logic    instWrEn;
    logic    dataWrEn;
    memAddrT wrAddr;
    wordT    wrData;
    logic    instCredit;
    logic    dataCredit;
    logic    instIdle;
    logic    dataIdle;
    wordT    instRdData;
    wordT    dataRdData;
    logic    rdSelQ;      // Lines up with the registered read

    resetController resetCtrl (
        .clk            (clk),
        .rstN           (rstN),
        .softwareReset  (softwareReset),
        .resetVector    (resetVector),
        .flashDone      (flashDone),
        .instFlashReq   (instFlashReq),
        .dataFlashReq   (dataFlashReq),
        .lockLocal      (lockLocal),
        .resetTrigger   (resetTrigger),
        .resetResponse  (resetResponse),
        .cpuResetLockout(cpuResetLockout)
    );

    flashSequencer sequencer (
        .clk         (clk),
        .rstN        (rstN),
        .flashInit   (flashInit),
        .lockLocal   (lockLocal),
        .instFlashReq(instFlashReq),
        .dataFlashReq(dataFlashReq),
        .instWrEn    (instWrEn),
        .dataWrEn    (dataWrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .instCredit  (instCredit),
        .dataCredit  (dataCredit),
        .instIdle    (instIdle),
        .dataIdle    (dataIdle),
        .flashDone   (flashDone),
        .systemEnable(systemEnable)
    );

    memoryBank instMem (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (instWrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .creditReturn(instCredit),
        .copyIdle    (instIdle),
        .rdAddr      (rdAddr),
        .rdData      (instRdData)
    );

    memoryBank dataMem (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (dataWrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .creditReturn(dataCredit),
        .copyIdle    (dataIdle),
        .rdAddr      (rdAddr),
        .rdData      (dataRdData)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdSelQ <= 1'b0;
        end else begin
            rdSelQ <= rdSel;
        end
    end

    assign rdData = rdSelQ ? dataRdData : instRdData;

endmodule

// File: memoryBank.sv
`include "memFlash_defs.svh"

module memoryBank import memFlashPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    wrEn,
    input  memAddrT wrAddr,
    input  wordT    wrData,
    output logic    creditReturn,
    output logic    copyIdle,
    input  memAddrT rdAddr,
    output wordT    rdData
);

    localparam int ptrBits   = $clog2(`QUEUE_DEPTH);
    localparam int countBits = $clog2(`QUEUE_DEPTH + 1);

    memAddrT              qAddr [`QUEUE_DEPTH];
    wordT                 qData [`QUEUE_DEPTH];
    logic [ptrBits-1:0]   wrPtr;
    logic [ptrBits-1:0]   rdPtr;
    logic [countBits-1:0] count;   // Entries waiting
    logic                 drain;
    wordT                 storage [`MEM_DEPTH];

    assign drain        = (count != '0); // Head moves every cycle it exists
    assign creditReturn = drain;
    assign copyIdle     = (count == '0);

    // Queue slots
    always_ff @(posedge clk) begin
        if (wrEn) begin
            qAddr[wrPtr] <= wrAddr;
            qData[wrPtr] <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (drain) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + countBits'(wrEn) - countBits'(drain);
        end
    end

    // Main array is zeroed by hardware reset so the I/O window reads zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                storage[i] <= '0;
            end
        end else if (drain) begin
            storage[qAddr[rdPtr]] <= qData[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        rdData <= storage[rdAddr]; // One-cycle read
    end

    noPushWhenFull: assert property (
        @(posedge clk) disable iff (!rstN) wrEn |-> (count < countBits'(`QUEUE_DEPTH))
    );

endmodule

// File: flashSequencer.sv
`include "memFlash_defs.svh"

module flashSequencer import memFlashPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    flashInit,
    input  logic    lockLocal,
    input  logic    instFlashReq,
    input  logic    dataFlashReq,
    output logic    instWrEn,
    output logic    dataWrEn,
    output memAddrT wrAddr,
    output wordT    wrData,
    input  logic    instCredit,
    input  logic    dataCredit,
    input  logic    instIdle,
    input  logic    dataIdle,
    output logic    flashDone,
    output logic    systemEnable
);

    localparam memAddrT lastAddr  = memAddrT'(`MEM_DEPTH - 1);
    localparam memAddrT skipFrom  = memAddrT'(`MEMMAP_START - 1); // Last word before the window
    localparam memAddrT skipTo    = memAddrT'(`MEMMAP_END + 1);
    localparam creditT  creditMax = creditT'(`QUEUE_DEPTH);

    seqPhaseT phase;
    logic     singleRun;   // Stop after the current phase
    logic     issueDone;   // Last word of the phase has been sent
    logic     poweredUp;
    memAddrT  addr;
    memAddrT  addrNext;
    creditT   instCredits;
    creditT   dataCredits;
    wordT     instWord;
    wordT     dataWord;
    logic     copying;
    logic     bankIdle;
    logic     bootStart;
    logic     instStart;
    logic     dataStart;
    logic     issue;
    logic     phaseEnd;

    flashRom #(.romKey(`INST_ROM_KEY)) instRom (
        .addr(addr),
        .data(instWord)
    );

    flashRom #(.romKey(`DATA_ROM_KEY)) dataRom (
        .addr(addr),
        .data(dataWord)
    );

    assign copying  = (phase == instCopy) || (phase == dataCopy);
    assign bankIdle = (phase == instCopy) ? instIdle : dataIdle;

    // New work is only picked up between copies
    assign bootStart = flashInit && !lockLocal && !copying;
    assign instStart = instFlashReq && !copying;
    assign dataStart = dataFlashReq && !copying;

    // A write needs a free slot in the target queue
    assign instWrEn = (phase == instCopy) && !issueDone && (instCredits != '0);
    assign dataWrEn = (phase == dataCopy) && !issueDone && (dataCredits != '0);
    assign issue    = instWrEn || dataWrEn;

    // Phase is over once the queue has drained its last entry
    assign phaseEnd  = copying && issueDone && bankIdle;
    assign flashDone = phaseEnd;

    // Step over the I/O window in data space
    assign addrNext = ((phase == dataCopy) && (addr == skipFrom)) ? skipTo : addr + 1'b1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase     <= off;
            singleRun <= 1'b0;
            issueDone <= 1'b0;
            addr      <= '0;
            poweredUp <= 1'b0;
        end else if (bootStart) begin
            phase     <= instCopy; // Full boot, both images
            singleRun <= 1'b0;
            issueDone <= 1'b0;
            addr      <= '0;
        end else if (instStart) begin
            phase     <= instCopy;
            singleRun <= 1'b1;
            issueDone <= 1'b0;
            addr      <= '0;
        end else if (dataStart) begin
            phase     <= dataCopy;
            singleRun <= 1'b1;
            issueDone <= 1'b0;
            addr      <= '0;
        end else if (phaseEnd) begin
            issueDone <= 1'b0;
            addr      <= '0;
            if ((phase == instCopy) && !singleRun) begin
                phase <= dataCopy;
            end else begin
                phase <= done;
                if (!singleRun) begin
                    poweredUp <= 1'b1;
                end
            end
        end else if (issue) begin
            if (addr == lastAddr) begin
                issueDone <= 1'b1;
            end else begin
                addr <= addrNext;
            end
        end
        // No credit means no issue, so the address simply holds
    end

    // Spend on write, regain on drain
    always_ff @(posedge clk) begin
        if (!rstN) begin
            instCredits <= creditMax;
            dataCredits <= creditMax;
        end else begin
            instCredits <= instCredits - creditT'(instWrEn) + creditT'(instCredit);
            dataCredits <= dataCredits - creditT'(dataWrEn) + creditT'(dataCredit);
        end
    end

    assign wrAddr       = addr;
    assign wrData       = (phase == dataCopy) ? dataWord : instWord;
    assign systemEnable = poweredUp;

    noWriteWithoutCredit: assert property (
        @(posedge clk) disable iff (!rstN)
        (instWrEn |-> instCredits != '0) and (dataWrEn |-> dataCredits != '0)
    );

    // Banks must never hand back more credits than were spent
    creditsBounded: assert property (
        @(posedge clk) disable iff (!rstN)
        (instCredits <= creditMax) && (dataCredits <= creditMax)
    );

endmodule

// File: resetController.sv
module resetController import memFlashPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       softwareReset,
    input  logic [3:0] resetVector,
    input  logic       flashDone,
    output logic       instFlashReq,
    output logic       dataFlashReq,
    output logic       lockLocal,
    output logic       resetTrigger,
    output logic       resetResponse,
    output logic       cpuResetLockout
);

    // Bit positions in the reset vector with the highest priority first
    localparam int fullBit = 3;
    localparam int instBit = 2;
    localparam int ioBit   = 1;
    localparam int dataBit = 0;

    resetStateT state;
    resetStateT stateNext;
    logic [3:0] pick;       // One-hot winner of the vector
    logic [3:0] active;     // Reset being serviced
    logic [3:0] activeNext;
    logic       lockout;    // Set by an IO reset
    logic       accept;

    // Priority encode
    always_comb begin
        pick = 4'b0000;
        if (resetVector[fullBit]) begin
            pick[fullBit] = 1'b1;
        end else if (resetVector[instBit]) begin
            pick[instBit] = 1'b1;
        end else if (resetVector[ioBit]) begin
            pick[ioBit] = 1'b1;
        end else if (resetVector[dataBit]) begin
            pick[dataBit] = 1'b1;
        end
    end

    // Requests are only taken in idle and never after an IO lockout
    assign accept = (state == idle) && softwareReset && (resetVector != 4'b0000) && !lockout;

    always_comb begin
        stateNext  = state;
        activeNext = active;
        case (state)
            idle: begin
                if (accept) begin
                    activeNext = pick;
                    if (pick[instBit]) begin
                        stateNext = flashInst;
                    end else if (pick[dataBit]) begin
                        stateNext = flashData;
                    end else begin
                        stateNext = submit; // Full and IO go straight out
                    end
                end
            end
            flashInst, flashData: begin
                if (flashDone) begin
                    stateNext = submit;
                end
            end
            submit:  stateNext = idle; // Always a single cycle
            default: stateNext = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state        <= idle;
            active       <= 4'b0000;
            lockout      <= 1'b0;
            instFlashReq <= 1'b0;
            dataFlashReq <= 1'b0;
        end else begin
            state        <= stateNext;
            active       <= activeNext;
            instFlashReq <= accept && pick[instBit]; // One-cycle pulses
            dataFlashReq <= accept && pick[dataBit];
            if ((state == submit) && active[ioBit]) begin
                lockout <= 1'b1; // Held until the next hardware reset
            end
        end
    end

    // Data resets answer and every other kind triggers the CPU reset
    assign resetTrigger  = (state == submit) && !active[dataBit];
    assign resetResponse = (state == submit) && active[dataBit];

    assign lockLocal = ((state == submit) && (active[instBit] || active[ioBit])) || lockout;
    assign cpuResetLockout = lockout;

    triggerResponseExclusive: assert property (
        @(posedge clk) disable iff (!rstN) !(resetTrigger && resetResponse)
    );

endmodule

// File: flashRom.sv
module flashRom import memFlashPkg::*; #(
    parameter wordT romKey = 16'h0000
) (
    input  memAddrT addr,
    output wordT    data
);

    wordT       mixed;    // Address folded with the key
    logic [2:0] rot;      // Rotate amount
    logic [31:0] doubled; // Two copies side by side for the rotate

    // Zero-extended address XOR key
    assign mixed = wordT'(addr) ^ romKey;

    assign rot = addr[2:0]; // Low address bits pick the rotation

    // Shifting the doubled word left leaves the rotated word in the top half
    assign doubled = {mixed, mixed} << rot;

    assign data = doubled[31:16];

endmodule

// File: memFlashPkg.sv
`include "memFlash_defs.svh"

package memFlashPkg;

    // One word of instruction or data memory
    typedef logic [15:0] wordT;

    // Word address into either memory
    typedef logic [`MEM_ADDR_BITS-1:0] memAddrT;

    // Software reset handling
    typedef enum logic [1:0] {
        idle,       // Waiting for a reset vector
        flashInst,  // Instruction image being rewritten
        flashData,  // Data image being rewritten
        submit      // Trigger or response goes out
    } resetStateT;

    // Copy engine progress
    typedef enum logic [1:0] {
        off,        // Nothing flashed since hardware reset
        instCopy,
        dataCopy,
        done
    } seqPhaseT;

    // Write credits held for one bank range from 0 to QUEUE_DEPTH
    typedef logic [2:0] creditT;

endpackage

// File: memFlash_defs.svh
`ifndef MEM_FLASH_DEFS_SVH
`define MEM_FLASH_DEFS_SVH

// Memory geometry
`define MEM_ADDR_BITS 10
`define MEM_DEPTH     1024

// Memory-mapped I/O window inside the data space is never flashed
`define MEMMAP_START  384
`define MEMMAP_END    511

// Write queue in front of each memory bank
// The sequencer starts with this many credits per bank
`define QUEUE_DEPTH   4

// Seeds for the two boot images
`define INST_ROM_KEY  16'hA5C3
`define DATA_ROM_KEY  16'h3C5A

`endif
